//--- source/ed_field_pkg.sv
package ed_field_pkg;

	localparam int FIELD_WIDTH = 255;

	// One reduced field element
	typedef logic [FIELD_WIDTH-1:0] felem_t;

	// Full double-width product
	typedef logic [2*FIELD_WIDTH-1:0] wide_t;

	// 2^255 - 19
	localparam felem_t Q = {{(FIELD_WIDTH - 5){1'b1}}, 5'b01101};

	// Newton iteration for the inverse mod 2^255
	// Q*Q is 1 mod 8, and each step doubles the number of good low bits
	function automatic felem_t calc_q_neg_inv();
		felem_t inv;
		inv = Q;
		for (int i = 0; i < 8; i++) begin
			inv = inv * (felem_t'(2) - Q * inv);
		end
		return -inv;
	endfunction

	// -Q^-1 mod 2^255
	localparam felem_t Q_NEG_INV = calc_q_neg_inv();

endpackage

//--- source/ed_stream_pkg.sv
package ed_stream_pkg;

	localparam int WORD_WIDTH = 64;

	typedef logic [WORD_WIDTH-1:0] word_t;

	// Words per field element on the stream
	localparam int WORDS_PER_ELEM = 4;

	// Low two bits of the command word
	typedef enum logic [1:0] {
		OP_ADD      = 2'd0,
		OP_SUB      = 2'd1,
		OP_MONT_MUL = 2'd2
	} opcode_e;

	typedef enum logic [1:0] {
		SEQ_IDLE,
		SEQ_RUN,
		SEQ_HANDOFF
	} seq_state_e;

endpackage

//--- source/operand_loader.sv
module operand_loader (
	input  logic                   i_clk,
	input  logic                   i_rst,
	input  logic                   i_in_valid,
	output logic                   o_in_ready,
	input  ed_stream_pkg::word_t   i_in_data,
	input  logic                   i_take,
	output logic                   o_cmd_valid,
	output ed_stream_pkg::opcode_e o_opcode,
	output ed_field_pkg::felem_t   o_a,
	output ed_field_pkg::felem_t   o_b
);

	localparam int ELEM_WORDS = ed_stream_pkg::WORDS_PER_ELEM;
	localparam int CMD_BEATS = 1 + 2 * ELEM_WORDS;
	localparam int CNT_W = $clog2(CMD_BEATS);
	localparam int KEEP_W = ed_field_pkg::FIELD_WIDTH - ed_stream_pkg::WORD_WIDTH;

	logic [CNT_W-1:0] beat_cnt;
	logic full_r;
	logic ready_r;
	logic beat_fire;
	logic last_beat;
	ed_stream_pkg::opcode_e opcode_r;
	ed_field_pkg::felem_t a_r;
	ed_field_pkg::felem_t b_r;

	assign beat_fire = i_in_valid && ready_r;
	assign last_beat = beat_fire && (beat_cnt == CNT_W'(CMD_BEATS - 1));

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			beat_cnt <= '0;
			full_r <= 1'b0;
			ready_r <= 1'b0;
		end else begin
			if (last_beat) begin
				beat_cnt <= '0;
				full_r <= 1'b1;
				ready_r <= 1'b0;
			end else begin
				if (beat_fire) begin
					beat_cnt <= beat_cnt + 1'b1;
				end
				if (i_take) begin
					full_r <= 1'b0;
				end
				ready_r <= !full_r || i_take;
			end
		end
	end

	// Command word, then A, then B, each element most significant word first
	always_ff @(posedge i_clk) begin
		if (beat_fire) begin
			if (beat_cnt == '0) begin
				opcode_r <= (i_in_data[1:0] == 2'd3) ? ed_stream_pkg::OP_ADD :
					ed_stream_pkg::opcode_e'(i_in_data[1:0]);
			end else if (beat_cnt <= CNT_W'(ELEM_WORDS)) begin
				a_r <= {a_r[KEEP_W-1:0], i_in_data};
			end else begin
				b_r <= {b_r[KEEP_W-1:0], i_in_data};
			end
		end
	end

	assign o_in_ready = ready_r;
	assign o_cmd_valid = full_r;
	assign o_opcode = opcode_r;
	assign o_a = a_r;
	assign o_b = b_r;

endmodule

//--- source/wide_mult.sv
module wide_mult #(
	parameter int DIGIT_WIDTH = 15
) (
	input  logic                 i_clk,
	input  logic                 i_rst,
	input  logic                 i_start,
	input  ed_field_pkg::felem_t i_x,
	input  ed_field_pkg::felem_t i_y,
	output logic                 o_done,
	output ed_field_pkg::wide_t  o_product
);

	localparam int FW = ed_field_pkg::FIELD_WIDTH;
	localparam int NUM_DIGITS = FW / DIGIT_WIDTH;
	localparam int CNT_W = $clog2(NUM_DIGITS + 1);
	localparam int PART_W = FW + DIGIT_WIDTH;

	ed_field_pkg::felem_t x_r;
	ed_field_pkg::felem_t y_r;
	ed_field_pkg::wide_t acc_r;
	logic [PART_W-1:0] partial;
	logic [CNT_W-1:0] digits_left;
	logic done_r;

	// x times the top digit of y, Horner style
	assign partial = PART_W'(x_r) * PART_W'(y_r[FW-1 -: DIGIT_WIDTH]);

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			digits_left <= '0;
			done_r <= 1'b0;
		end else begin
			done_r <= !i_start && (digits_left == CNT_W'(1));
			if (i_start) begin
				digits_left <= CNT_W'(NUM_DIGITS);
			end else if (digits_left != '0) begin
				digits_left <= digits_left - 1'b1;
			end
		end
	end

	always_ff @(posedge i_clk) begin
		if (i_start) begin
			x_r <= i_x;
			y_r <= i_y;
			acc_r <= '0;
		end else if (digits_left != '0) begin
			acc_r <= (acc_r << DIGIT_WIDTH) + ed_field_pkg::wide_t'(partial);
			y_r <= y_r << DIGIT_WIDTH;
		end
	end

	assign o_done = done_r;
	assign o_product = acc_r;

endmodule

//--- source/mont_mult.sv
module mont_mult #(
	parameter int DIGIT_WIDTH = 15
) (
	input  logic                 i_clk,
	input  logic                 i_rst,
	input  logic                 i_start,
	input  ed_field_pkg::felem_t i_a,
	input  ed_field_pkg::felem_t i_b,
	output logic                 o_done,
	output ed_field_pkg::felem_t o_result
);

	localparam int FW = ed_field_pkg::FIELD_WIDTH;

	typedef enum logic [2:0] {
		MM_IDLE,
		MM_AB,
		MM_NINV,
		MM_Q,
		MM_REDUCE
	} mm_state_e;

	mm_state_e state;
	logic mult_start;
	logic mult_done;
	ed_field_pkg::felem_t mult_x;
	ed_field_pkg::felem_t mult_y;
	ed_field_pkg::wide_t product;
	ed_field_pkg::felem_t prod_lo;
	ed_field_pkg::felem_t prod_hi;
	ed_field_pkg::wide_t t_r;
	logic [FW:0] lo_sum;
	ed_field_pkg::felem_t hi_a_r;
	ed_field_pkg::felem_t hi_b_r;
	logic [FW:0] hi_sum;
	logic [FW:0] hi_red;
	ed_field_pkg::felem_t result_r;
	logic done_r;

	assign prod_lo = product[FW-1:0];
	assign prod_hi = product[2*FW-1:FW];

	// a*b first, then low*Q_NEG_INV, then m*Q
	always_comb begin
		mult_x = prod_lo;
		mult_y = ed_field_pkg::Q;
		if (state == MM_IDLE) begin
			mult_x = i_a;
			mult_y = i_b;
		end else if (state == MM_AB) begin
			mult_y = ed_field_pkg::Q_NEG_INV;
		end
	end

	assign mult_start = (state == MM_IDLE) ? i_start :
		(mult_done && (state == MM_AB || state == MM_NINV));

	wide_mult #(
		.DIGIT_WIDTH(DIGIT_WIDTH)
	) u_mult (
		.i_clk    (i_clk),
		.i_rst    (i_rst),
		.i_start  (mult_start),
		.i_x      (mult_x),
		.i_y      (mult_y),
		.o_done   (mult_done),
		.o_product(product)
	);

	// Stage one only needs the carry out of the low halves
	assign lo_sum = {1'b0, t_r[FW-1:0]} + {1'b0, prod_lo};

	// Stage two, the sum stays below 2Q
	assign hi_sum = {1'b0, hi_a_r} + {1'b0, hi_b_r};
	assign hi_red = hi_sum - {1'b0, ed_field_pkg::Q};

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			state <= MM_IDLE;
			done_r <= 1'b0;
		end else begin
			done_r <= 1'b0;
			case (state)
				MM_IDLE: if (i_start) state <= MM_AB;
				MM_AB: if (mult_done) state <= MM_NINV;
				MM_NINV: if (mult_done) state <= MM_Q;
				MM_Q: if (mult_done) state <= MM_REDUCE;
				MM_REDUCE: begin
					state <= MM_IDLE;
					done_r <= 1'b1;
				end
				default: state <= MM_IDLE;
			endcase
		end
	end

	always_ff @(posedge i_clk) begin
		if (state == MM_AB && mult_done) begin
			t_r <= product;
		end
		if (state == MM_Q && mult_done) begin
			hi_a_r <= t_r[2*FW-1:FW];
			hi_b_r <= prod_hi + FW'(lo_sum[FW]);
		end
		if (state == MM_REDUCE) begin
			result_r <= (hi_sum >= {1'b0, ed_field_pkg::Q}) ? hi_red[FW-1:0] : hi_sum[FW-1:0];
		end
	end

	assign o_done = done_r;
	assign o_result = result_r;

endmodule

//--- source/field_add_sub.sv
module field_add_sub (
	input  logic                 i_clk,
	input  logic                 i_rst,
	input  logic                 i_start,
	input  logic                 i_sub,
	input  ed_field_pkg::felem_t i_a,
	input  ed_field_pkg::felem_t i_b,
	output logic                 o_done,
	output ed_field_pkg::felem_t o_result
);

	localparam int FW = ed_field_pkg::FIELD_WIDTH;

	logic [FW:0] sum;
	logic [FW:0] sum_red;
	logic borrow;
	ed_field_pkg::felem_t add_res;
	ed_field_pkg::felem_t sub_res;
	ed_field_pkg::felem_t result_r;
	logic done_r;

	assign sum = {1'b0, i_a} + {1'b0, i_b};
	assign sum_red = sum - {1'b0, ed_field_pkg::Q};
	assign add_res = (sum >= {1'b0, ed_field_pkg::Q}) ? sum_red[FW-1:0] : sum[FW-1:0];

	// Wraps mod 2^255 and comes back in range once Q is added
	assign borrow = i_a < i_b;
	assign sub_res = i_a - i_b + (borrow ? ed_field_pkg::Q : '0);

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			done_r <= 1'b0;
		end else begin
			done_r <= i_start;
		end
	end

	always_ff @(posedge i_clk) begin
		if (i_start) begin
			result_r <= i_sub ? sub_res : add_res;
		end
	end

	assign o_done = done_r;
	assign o_result = result_r;

endmodule

//--- source/result_unloader.sv
module result_unloader (
	input  logic                 i_clk,
	input  logic                 i_rst,
	input  logic                 i_result_valid,
	input  ed_field_pkg::felem_t i_result,
	output logic                 o_busy,
	output logic                 o_out_valid,
	input  logic                 i_out_ready,
	output ed_stream_pkg::word_t o_out_data
);

	localparam int WW = ed_stream_pkg::WORD_WIDTH;
	localparam int ELEM_WORDS = ed_stream_pkg::WORDS_PER_ELEM;
	localparam int SHIFT_W = ELEM_WORDS * WW;
	localparam int CNT_W = $clog2(ELEM_WORDS);

	logic [SHIFT_W-1:0] shift_r;
	logic [CNT_W-1:0] beat_cnt;
	logic valid_r;
	logic beat_fire;

	assign beat_fire = valid_r && i_out_ready;

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			valid_r <= 1'b0;
			beat_cnt <= '0;
		end else if (i_result_valid) begin
			valid_r <= 1'b1;
			beat_cnt <= '0;
		end else if (beat_fire) begin
			beat_cnt <= beat_cnt + 1'b1;
			if (beat_cnt == CNT_W'(ELEM_WORDS - 1)) begin
				valid_r <= 1'b0;
			end
		end
	end

	// Zero extension leaves bit 63 of the top word clear
	always_ff @(posedge i_clk) begin
		if (i_result_valid) begin
			shift_r <= SHIFT_W'(i_result);
		end else if (beat_fire) begin
			shift_r <= shift_r << WW;
		end
	end

	assign o_busy = valid_r;
	assign o_out_valid = valid_r;
	assign o_out_data = shift_r[SHIFT_W-1 -: WW];

endmodule

//--- source/field_op_sequencer.sv
module field_op_sequencer (
	input  logic                   i_clk,
	input  logic                   i_rst,
	input  logic                   i_cmd_valid,
	input  ed_stream_pkg::opcode_e i_opcode,
	output logic                   o_take,
	output logic                   o_start_mul,
	output logic                   o_start_add,
	output logic                   o_sub,
	input  logic                   i_mul_done,
	input  ed_field_pkg::felem_t   i_mul_result,
	input  logic                   i_add_done,
	input  ed_field_pkg::felem_t   i_add_result,
	input  logic                   i_unload_busy,
	output logic                   o_result_valid,
	output ed_field_pkg::felem_t   o_result
);

	ed_stream_pkg::seq_state_e state;
	logic take_r;
	logic start_mul_r;
	logic start_add_r;
	logic sub_r;
	logic result_valid_r;
	ed_field_pkg::felem_t result_r;

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			state <= ed_stream_pkg::SEQ_IDLE;
			take_r <= 1'b0;
			start_mul_r <= 1'b0;
			start_add_r <= 1'b0;
			result_valid_r <= 1'b0;
		end else begin
			take_r <= 1'b0;
			start_mul_r <= 1'b0;
			start_add_r <= 1'b0;
			result_valid_r <= 1'b0;
			case (state)
				ed_stream_pkg::SEQ_IDLE: begin
					if (i_cmd_valid) begin
						take_r <= 1'b1;
						start_mul_r <= (i_opcode == ed_stream_pkg::OP_MONT_MUL);
						start_add_r <= (i_opcode != ed_stream_pkg::OP_MONT_MUL);
						state <= ed_stream_pkg::SEQ_RUN;
					end
				end
				ed_stream_pkg::SEQ_RUN: begin
					if (i_mul_done || i_add_done) begin
						state <= ed_stream_pkg::SEQ_HANDOFF;
					end
				end
				ed_stream_pkg::SEQ_HANDOFF: begin
					// Wait for the previous result to drain
					if (!i_unload_busy) begin
						result_valid_r <= 1'b1;
						state <= ed_stream_pkg::SEQ_IDLE;
					end
				end
				default: state <= ed_stream_pkg::SEQ_IDLE;
			endcase
		end
	end

	always_ff @(posedge i_clk) begin
		if (state == ed_stream_pkg::SEQ_IDLE && i_cmd_valid) begin
			sub_r <= (i_opcode == ed_stream_pkg::OP_SUB);
		end
		if (state == ed_stream_pkg::SEQ_RUN && (i_mul_done || i_add_done)) begin
			result_r <= i_mul_done ? i_mul_result : i_add_result;
		end
	end

	assign o_take = take_r;
	assign o_start_mul = start_mul_r;
	assign o_start_add = start_add_r;
	assign o_sub = sub_r;
	assign o_result_valid = result_valid_r;
	assign o_result = result_r;

endmodule

//--- source/ed25519_field_unit.sv
module ed25519_field_unit #(
	parameter int DIGIT_WIDTH = 15
) (
	input  logic                 i_clk,
	input  logic                 i_rst,
	input  logic                 i_in_valid,
	output logic                 o_in_ready,
	input  ed_stream_pkg::word_t i_in_data,
	output logic                 o_out_valid,
	input  logic                 i_out_ready,
	output ed_stream_pkg::word_t o_out_data
);

	logic take;
	logic cmd_valid;
	ed_stream_pkg::opcode_e opcode;
	ed_field_pkg::felem_t op_a;
	ed_field_pkg::felem_t op_b;
	logic start_mul;
	logic start_add;
	logic sub;
	logic mul_done;
	logic add_done;
	ed_field_pkg::felem_t mul_result;
	ed_field_pkg::felem_t add_result;
	logic unload_busy;
	logic result_valid;
	ed_field_pkg::felem_t result;

	operand_loader u_loader (
		.i_clk      (i_clk),
		.i_rst      (i_rst),
		.i_in_valid (i_in_valid),
		.o_in_ready (o_in_ready),
		.i_in_data  (i_in_data),
		.i_take     (take),
		.o_cmd_valid(cmd_valid),
		.o_opcode   (opcode),
		.o_a        (op_a),
		.o_b        (op_b)
	);

	mont_mult #(
		.DIGIT_WIDTH(DIGIT_WIDTH)
	) u_mont (
		.i_clk   (i_clk),
		.i_rst   (i_rst),
		.i_start (start_mul),
		.i_a     (op_a),
		.i_b     (op_b),
		.o_done  (mul_done),
		.o_result(mul_result)
	);

	field_add_sub u_add_sub (
		.i_clk   (i_clk),
		.i_rst   (i_rst),
		.i_start (start_add),
		.i_sub   (sub),
		.i_a     (op_a),
		.i_b     (op_b),
		.o_done  (add_done),
		.o_result(add_result)
	);

	field_op_sequencer u_seq (
		.i_clk         (i_clk),
		.i_rst         (i_rst),
		.i_cmd_valid   (cmd_valid),
		.i_opcode      (opcode),
		.o_take        (take),
		.o_start_mul   (start_mul),
		.o_start_add   (start_add),
		.o_sub         (sub),
		.i_mul_done    (mul_done),
		.i_mul_result  (mul_result),
		.i_add_done    (add_done),
		.i_add_result  (add_result),
		.i_unload_busy (unload_busy),
		.o_result_valid(result_valid),
		.o_result      (result)
	);

	result_unloader u_unloader (
		.i_clk         (i_clk),
		.i_rst         (i_rst),
		.i_result_valid(result_valid),
		.i_result      (result),
		.o_busy        (unload_busy),
		.o_out_valid   (o_out_valid),
		.i_out_ready   (i_out_ready),
		.o_out_data    (o_out_data)
	);

endmodule

//--- sim/field_model.svh
`ifndef FIELD_MODEL_SVH
`define FIELD_MODEL_SVH

// 2^255 - 19, kept wide so sums never overflow
localparam logic [256:0] MODEL_Q = (257'd1 << 255) - 257'd19;

// (a + b) mod q for reduced a and b
function automatic logic [254:0] add_mod(input logic [254:0] a, input logic [254:0] b);
	logic [256:0] s;
	s = {2'b00, a} + {2'b00, b};
	if (s >= MODEL_Q) begin
		s = s - MODEL_Q;
	end
	return s[254:0];
endfunction

// (a - b) mod q, lifted by q first so it never goes negative
function automatic logic [254:0] sub_mod(input logic [254:0] a, input logic [254:0] b);
	logic [256:0] d;
	d = {2'b00, a} + MODEL_Q - {2'b00, b};
	if (d >= MODEL_Q) begin
		d = d - MODEL_Q;
	end
	return d[254:0];
endfunction

// a * b * 2^-255 mod q, one bit of a per step from the bottom
function automatic logic [254:0] mont_mul_bitserial(input logic [254:0] a,
		input logic [254:0] b);
	logic [257:0] t;
	t = '0;
	for (int i = 0; i < 255; i++) begin
		if (a[i]) begin
			t = t + {3'b000, b};
		end
		// Make t even so the halving is exact mod q
		if (t[0]) begin
			t = t + {1'b0, MODEL_Q};
		end
		t = t >> 1;
	end
	if (t >= {1'b0, MODEL_Q}) begin
		t = t - {1'b0, MODEL_Q};
	end
	return t[254:0];
endfunction

`endif

//--- sim/tb_field_unit.sv
module tb_field_unit;

	localparam int DIGIT_WIDTH = 15;
	localparam int CLK_PERIOD = 40;
	localparam int RESET_CYCLES = 10;
	localparam int NUM_CMDS = 200;
	localparam int MONT_LAT = 3 * (255 / DIGIT_WIDTH + 1) + 2;
	localparam int SLACK = 4;
	localparam longint TIMEOUT = longint'(RESET_CYCLES + NUM_CMDS * (13 + MONT_LAT) * SLACK)
		* CLK_PERIOD;

	logic i_clk;
	logic i_rst;
	logic i_in_valid;
	logic o_in_ready;
	logic [63:0] i_in_data;
	logic o_out_valid;
	logic i_out_ready;
	logic [63:0] o_out_data;

	integer seed;
	logic [254:0] exp_q[$];
	logic [63:0] out_words[4];
	int out_beat;
	int results_seen;
	logic hold_pending;
	logic [63:0] hold_data;

	`include "field_model.svh"

	ed25519_field_unit #(
		.DIGIT_WIDTH(DIGIT_WIDTH)
	) u_dut (
		.i_clk      (i_clk),
		.i_rst      (i_rst),
		.i_in_valid (i_in_valid),
		.o_in_ready (o_in_ready),
		.i_in_data  (i_in_data),
		.o_out_valid(o_out_valid),
		.i_out_ready(i_out_ready),
		.o_out_data (o_out_data)
	);

	always #(CLK_PERIOD / 2) i_clk = ~i_clk;

	task automatic end_with_failure(input string reason);
		$display("%s", reason);
		$display("Finished with errors");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [255:0] got,
			input logic [255:0] exp);
		if (got !== exp) begin
			end_with_failure($sformatf("error: %s got %h expected %h", name, got, exp));
		end
	endtask

	// Random element below q with 0, 1 and q-1 mixed in
	task automatic pick_operand(output logic [254:0] v);
		int sel;
		logic [255:0] raw;
		sel = $unsigned($random(seed)) % 8;
		for (int i = 0; i < 8; i++) begin
			raw[32*i +: 32] = $random(seed);
		end
		v = raw[254:0];
		if ({2'b00, v} >= MODEL_Q) begin
			v = v - MODEL_Q[254:0];
		end
		if (sel == 0) v = '0;
		if (sel == 1) v = 255'd1;
		if (sel == 2) v = MODEL_Q[254:0] - 255'd1;
	endtask

	task automatic send_word(input logic [63:0] word);
		int gap;
		gap = $unsigned($random(seed)) % 3;
		repeat (gap) begin
			@(posedge i_clk);
			#1;
		end
		i_in_valid = 1'b1;
		i_in_data = word;
		@(negedge i_clk);
		while (!o_in_ready) @(negedge i_clk);
		@(posedge i_clk);
		#1;
		i_in_valid = 1'b0;
		i_in_data = '0;
	endtask

	task automatic send_command();
		logic [63:0] cmd;
		logic [254:0] a;
		logic [254:0] b;
		logic [255:0] a_full;
		logic [255:0] b_full;
		cmd = {$random(seed), $random(seed)};
		pick_operand(a);
		pick_operand(b);
		// Opcode 3 behaves like an add
		case (cmd[1:0])
			2'd1: exp_q.push_back(sub_mod(a, b));
			2'd2: exp_q.push_back(mont_mul_bitserial(a, b));
			default: exp_q.push_back(add_mod(a, b));
		endcase
		// Bit 255 of each element is dropped by the DUT
		a_full = {1'($random(seed)), a};
		b_full = {1'($random(seed)), b};
		send_word(cmd);
		for (int i = 3; i >= 0; i--) send_word(a_full[64*i +: 64]);
		for (int i = 3; i >= 0; i--) send_word(b_full[64*i +: 64]);
	endtask

	always @(posedge i_clk) begin
		#1;
		i_out_ready = ($unsigned($random(seed)) % 4) != 0;
	end

	// Output stream sampled on the falling edge
	initial begin : out_monitor
		logic [255:0] got;
		forever begin
			@(negedge i_clk);
			if (hold_pending && !o_out_valid) begin
				end_with_failure("o_out_valid dropped before the held word was accepted");
			end
			if (!i_rst && o_out_valid) begin
				if (hold_pending) begin
					check_value("o_out_data", {192'd0, o_out_data}, {192'd0, hold_data});
				end
				if (i_out_ready) begin
					hold_pending = 1'b0;
					out_words[out_beat] = o_out_data;
					out_beat = out_beat + 1;
					if (out_beat == 4) begin
						out_beat = 0;
						got = {out_words[0], out_words[1], out_words[2], out_words[3]};
						if (exp_q.size() == 0) begin
							end_with_failure("Result came out with no command pending");
						end
						check_value("o_out_data[63]", {255'd0, got[255]}, 256'd0);
						check_value("o_out_data", got, {1'b0, exp_q.pop_front()});
						results_seen = results_seen + 1;
					end
				end else begin
					hold_pending = 1'b1;
					hold_data = o_out_data;
				end
			end
		end
	end

	initial begin : watchdog
		#(TIMEOUT);
		end_with_failure("Timeout waiting for results from the DUT");
	end

	initial begin : main
		seed = 61;
		i_clk = 1'b0;
		i_rst = 1'b1;
		i_in_valid = 1'b0;
		i_in_data = '0;
		i_out_ready = 1'b0;
		out_beat = 0;
		results_seen = 0;
		hold_pending = 1'b0;
		hold_data = '0;
		repeat (RESET_CYCLES) begin
			@(posedge i_clk);
			#1;
			check_value("o_in_ready", {255'd0, o_in_ready}, 256'd0);
			check_value("o_out_valid", {255'd0, o_out_valid}, 256'd0);
		end
		i_rst = 1'b0;
		@(posedge i_clk);
		#1;
		check_value("o_in_ready", {255'd0, o_in_ready}, 256'd1);
		check_value("o_out_valid", {255'd0, o_out_valid}, 256'd0);
		for (int n = 0; n < NUM_CMDS; n++) begin
			send_command();
		end
		wait (results_seen == NUM_CMDS);
		repeat (8) @(posedge i_clk);
		#1;
		if (!o_out_valid && out_beat == 0) begin
			$display("Finished with no errors");
			$finish;
		end else begin
			end_with_failure("Output stream still active after the last result");
		end
	end

endmodule

//--- sources.f
+incdir+sim
source/ed_field_pkg.sv
source/ed_stream_pkg.sv
source/operand_loader.sv
source/wide_mult.sv
source/mont_mult.sv
source/field_add_sub.sv
source/result_unloader.sv
source/field_op_sequencer.sv
source/ed25519_field_unit.sv
sim/tb_field_unit.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the field unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_field_unit \
	-Mdir obj_dir -o tb_field_unit -f sources.f
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit $status
fi

./obj_dir/tb_field_unit
status=$?
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit $status
fi

exit 0
